// File: Makefile
VERILATOR ?= verilator
TOP ?= lsuTb
RTL_TOP ?= lsuTop
FILELIST ?= lsu.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/lsuPkg.sv
`include "lsu_defs.svh"

package lsuPkg;

    typedef logic [`TAG_W-1:0] tagT;   // Names an operation in the reorder buffer.

    // Access length. 0 is a byte, 1 is a half and 3 is a word.
    typedef logic [1:0] lenT;

    // Data cache FSM.
    typedef enum logic [1:0] {CS_IDLE, CS_LOOKUP, CS_WAITMEM} cacheStateT;

    // Memory controller FSM.
    typedef enum logic [1:0] {MC_IDLE, MC_ACCESS, MC_FINISH} mcStateT;

endpackage

// File: common/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Address and data widths of the load/store path.
`define ADDR_W 32
`define DATA_W 32

`define TAG_W 4          // Reorder tag that names an operation.

// Number of operations the buffer can hold.
`define LSB_DEPTH 4

// One-word lines, so the index sits directly above the byte offset.
`define CACHE_LINES 16
`define INDEX_W 4

`endif

// File: common/memPkg.sv
`include "lsu_defs.svh"

// Vector types on the memory side of the load/store path.
package memPkg;

    typedef logic [`ADDR_W-1:0] addrT;

    typedef logic [`DATA_W-1:0] dataT;

    // One byte on the RAM port.
    typedef logic [7:0] byteT;

endpackage

// File: lsb/loadStoreBuffer.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module loadStoreBuffer
    import memPkg::*, lsuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic opValid,
    input  logic opStore,
    input  addrT opAddr,
    input  dataT opData,
    input  lenT  opLen,
    input  tagT  opTag,
    output logic full,
    input  logic cacheReady,
    output logic reqEn,
    output logic reqStore,
    output addrT reqAddr,
    output dataT reqData,
    output lenT  reqLen,
    output tagT  reqTag,
    input  logic doneEn,
    input  dataT doneData,
    input  tagT  doneTag,
    output logic resultValid,
    output dataT resultData,
    output tagT  resultTag
);
    localparam int PTR_W = $clog2(`LSB_DEPTH);
    localparam int CNT_W = $clog2(`LSB_DEPTH + 1);

    logic entStore [`LSB_DEPTH];
    addrT entAddr [`LSB_DEPTH];
    dataT entData [`LSB_DEPTH];
    lenT  entLen [`LSB_DEPTH];
    tagT  entTag [`LSB_DEPTH];

    logic [PTR_W-1:0] headPtr;
    logic [PTR_W-1:0] tailPtr;
    logic [CNT_W-1:0] count;
    logic headIssued;        // The head sits in the cache and waits for its result.
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`LSB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(`LSB_DEPTH));
    assign push = rdy && opValid && !full;
    assign pop = rdy && doneEn;   // The cache completes in order, so a result retires the head.

    assign reqEn = cacheReady && (count != '0) && !headIssued;
    assign reqStore = entStore[headPtr];
    assign reqAddr = entAddr[headPtr];
    assign reqData = entData[headPtr];
    assign reqLen = entLen[headPtr];
    assign reqTag = entTag[headPtr];

    assign resultValid = pop;
    assign resultData = doneData;
    assign resultTag = doneTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            headIssued <= 1'b0;
        end else if (rdy) begin
            if (push) tailPtr <= nextPtr(tailPtr);
            if (pop) headPtr <= nextPtr(headPtr);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
            if (pop) headIssued <= 1'b0;
            else if (reqEn) headIssued <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entStore[tailPtr] <= opStore;
            entAddr[tailPtr] <= opAddr;
            entData[tailPtr] <= opData;
            entLen[tailPtr] <= opLen;
            entTag[tailPtr] <= opTag;
        end
    end

endmodule

// File: lsu.f
+incdir+common
common/memPkg.sv
common/lsuPkg.sv
lsb/loadStoreBuffer.sv
src/dataCache.sv
src/memCtrl.sv
src/lsuTop.sv
testbench/ramModel.sv
testbench/lsuTb.sv

// File: src/dataCache.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module dataCache
    import memPkg::*, lsuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    output logic cacheReady,
    input  logic reqEn,
    input  logic reqStore,
    input  addrT reqAddr,
    input  dataT reqData,
    input  lenT  reqLen,
    input  tagT  reqTag,
    output logic doneEn,
    output dataT doneData,
    output tagT  doneTag,
    output logic mcEn,
    output logic mcStore,
    output addrT mcAddr,
    output dataT mcData,
    output lenT  mcLen,
    input  logic mcDone,
    input  dataT mcRdata
);
    localparam int LTAG_W = `ADDR_W - `INDEX_W - 2;

    cacheStateT state;
    logic curStore;
    addrT curAddr;
    dataT curData;
    lenT  curLen;
    tagT  curTag;

    logic [`CACHE_LINES-1:0] lineValid;
    logic [LTAG_W-1:0] lineTag [`CACHE_LINES];
    dataT lineData [`CACHE_LINES];
    logic [`INDEX_W-1:0] idx;
    logic hit;

    // Loaded bytes and halves come back zero-extended.
    function automatic dataT loadSelect(input dataT word, input logic [1:0] off, input lenT len);
        dataT shifted;
        shifted = word >> {off, 3'b000};
        case (len)
            2'd0:    return dataT'(shifted[7:0]);
            2'd1:    return dataT'(shifted[15:0]);
            default: return shifted;
        endcase
    endfunction

    function automatic dataT storeMerge(input dataT word, input logic [1:0] off, input lenT len,
                                        input dataT data);
        dataT mask;
        case (len)
            2'd0:    mask = dataT'(8'hff);
            2'd1:    mask = dataT'(16'hffff);
            default: mask = '1;
        endcase
        mask = mask << {off, 3'b000};
        return (word & ~mask) | ((data << {off, 3'b000}) & mask);
    endfunction

    assign cacheReady = rdy && (state == CS_IDLE);
    assign idx = curAddr[`INDEX_W+1:2];
    assign hit = lineValid[idx] && (lineTag[idx] == curAddr[`ADDR_W-1:`INDEX_W+2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CS_IDLE;
            lineValid <= '0;
            doneEn <= 1'b0;
            mcEn <= 1'b0;
        end else if (rdy) begin
            doneEn <= 1'b0;
            mcEn <= 1'b0;
            case (state)
                CS_IDLE: if (reqEn) begin
                    curStore <= reqStore;
                    curAddr <= reqAddr;
                    curData <= reqData;
                    curLen <= reqLen;
                    curTag <= reqTag;
                    state <= CS_LOOKUP;
                end
                CS_LOOKUP: if (curStore || !hit) begin
                    mcEn <= 1'b1;
                    mcStore <= curStore;
                    mcAddr <= curStore ? curAddr : {curAddr[`ADDR_W-1:2], 2'b00};
                    mcData <= curData;
                    mcLen <= curStore ? curLen : 2'd3;   // A miss always fetches the whole word.
                    if (curStore && hit) lineData[idx] <= storeMerge(lineData[idx], curAddr[1:0],
                                                                     curLen, curData);
                    state <= CS_WAITMEM;
                end else begin
                    doneEn <= 1'b1;
                    doneData <= loadSelect(lineData[idx], curAddr[1:0], curLen);
                    doneTag <= curTag;
                    state <= CS_IDLE;
                end
                CS_WAITMEM: if (mcDone) begin
                    doneEn <= 1'b1;
                    doneTag <= curTag;
                    if (curStore) begin
                        doneData <= '0;
                    end else begin
                        doneData <= loadSelect(mcRdata, curAddr[1:0], curLen);
                        lineData[idx] <= mcRdata;
                        lineTag[idx] <= curAddr[`ADDR_W-1:`INDEX_W+2];
                        lineValid[idx] <= 1'b1;
                    end
                    state <= CS_IDLE;
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

endmodule

// File: src/lsuTop.sv
`timescale 1ns/1ps

module lsuTop
    import memPkg::*, lsuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic opValid,
    input  logic opStore,
    input  addrT opAddr,
    input  dataT opData,
    input  lenT  opLen,
    input  tagT  opTag,
    output logic full,
    output logic resultValid,
    output dataT resultData,
    output tagT  resultTag,
    output addrT ramAddr,
    output logic ramWrite,
    output byteT ramWdata,
    input  byteT ramRdata,
    input  logic memWait
);
    // Buffer to cache.
    logic cacheReady;
    logic reqEn;
    logic reqStore;
    addrT reqAddr;
    dataT reqData;
    lenT  reqLen;
    tagT  reqTag;
    logic doneEn;
    dataT doneData;
    tagT  doneTag;

    // Cache to controller.
    logic mcEn;
    logic mcStore;
    addrT mcAddr;
    dataT mcData;
    lenT  mcLen;
    logic mcDone;
    dataT mcRdata;

    loadStoreBuffer u_loadStoreBuffer (.*);
    dataCache u_dataCache (.*);
    memCtrl u_memCtrl (.*);

endmodule

// File: src/memCtrl.sv
`timescale 1ns/1ps

module memCtrl
    import memPkg::*, lsuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic mcEn,
    input  logic mcStore,
    input  addrT mcAddr,
    input  dataT mcData,
    input  lenT  mcLen,
    output logic mcDone,
    output dataT mcRdata,
    output addrT ramAddr,
    output logic ramWrite,
    output byteT ramWdata,
    input  byteT ramRdata,
    input  logic memWait
);
    mcStateT state;
    logic isStore;
    addrT baseAddr;
    dataT wData;
    lenT  len;
    logic [1:0] byteCnt;     // Byte on the RAM port this cycle.
    dataT rdBuf;
    logic rdPend;            // A read address went out last cycle.
    logic [1:0] rdIdx;

    assign ramAddr = baseAddr + addrT'(byteCnt);
    assign ramWrite = rdy && (state == MC_ACCESS) && isStore && !memWait;
    assign ramWdata = wData[{byteCnt, 3'b000} +: 8];

    // The last read byte arrives in FINISH and is merged straight into the result.
    assign mcDone = (state == MC_FINISH);
    assign mcRdata = rdPend ? (rdBuf | (dataT'(ramRdata) << {rdIdx, 3'b000})) : rdBuf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MC_IDLE;
            byteCnt <= '0;
            rdPend <= 1'b0;
        end else if (rdy) begin
            case (state)
                MC_IDLE: if (mcEn) begin
                    isStore <= mcStore;
                    baseAddr <= mcAddr;
                    wData <= mcData;
                    len <= mcLen;
                    byteCnt <= '0;
                    rdBuf <= '0;
                    rdPend <= 1'b0;
                    state <= MC_ACCESS;
                end
                MC_ACCESS: begin
                    if (rdPend) rdBuf[{rdIdx, 3'b000} +: 8] <= ramRdata;
                    if (!memWait) begin
                        rdPend <= !isStore;
                        rdIdx <= byteCnt;
                        if (byteCnt == len) state <= MC_FINISH;
                        else byteCnt <= byteCnt + 1'b1;
                    end else begin
                        rdPend <= 1'b0;   // The address is held until the wait drops.
                    end
                end
                MC_FINISH: begin
                    rdPend <= 1'b0;
                    state <= MC_IDLE;
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

endmodule

// File: testbench/lsuTb.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsuTb
    import memPkg::*, lsuPkg::*;
();
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * 2000;

    typedef struct packed {
        logic store;
        logic [9:0] addr;
        dataT data;
        lenT  len;
        tagT  tag;
        dataT exp;
    } opT;

    logic clk;
    logic rst;
    logic rdy;
    logic opValid;
    logic opStore;
    addrT opAddr;
    dataT opData;
    lenT  opLen;
    tagT  opTag;
    logic full;
    logic resultValid;
    dataT resultData;
    tagT  resultTag;
    addrT ramAddr;
    logic ramWrite;
    byteT ramWdata;
    byteT ramRdata;
    logic memWait;

    byteT sbMem [1024];      // Expected memory contents.
    opT   ops [$];
    dataT resData [$];
    tagT  resTag [$];
    tagT  nextTag;
    logic [31:0] lfsr;
    int   readSteps;
    addrT lastRamAddr;
    string testName;

    lsuTop u_lsuTop (.*);
    ramModel #(.BYTES(1024)) u_ramModel (.*);

    always #4 clk = ~clk;

    // Results and read address steps as they stand just before each rising edge.
    always @(posedge clk) begin
        if (!rst && resultValid) begin
            resData.push_back(resultData);
            resTag.push_back(resultTag);
        end
        if (!rst && !ramWrite && ramAddr != lastRamAddr) readSteps++;
        lastRamAddr = ramAddr;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
        return v;
    endfunction

    function automatic logic [9:0] randAddr(input lenT len);
        logic [9:0] a;
        a = 10'(randBits(10));
        if (len == 2'd1) a[0] = 1'b0;
        else if (len == 2'd3) a[1:0] = 2'b00;
        return a;
    endfunction

    // Little-endian assembly, zero-extended to the access length.
    function automatic dataT loadExpect(input logic [9:0] a, input lenT len);
        dataT word;
        word = {sbMem[a + 10'd3], sbMem[a + 10'd2], sbMem[a + 10'd1], sbMem[a]};
        case (len)
            2'd0:    return {24'b0, word[7:0]};
            2'd1:    return {16'b0, word[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic checkValue(input dataT expected, input dataT actual);
        if (actual !== expected) begin
            $display("Error in %s: expected %h, actual %h", testName, expected, actual);
            $display("Test failed");
            $fatal(1, "Check failed in %s", testName);
        end
    endtask

    task automatic checkRam(input logic [9:0] start, input int n);
        logic [9:0] a;
        for (int i = 0; i < n; i++) begin
            a = start + 10'(i);
            checkValue(dataT'(sbMem[a]), dataT'(u_ramModel.mem[a]));
        end
    endtask

    task automatic queueOp(input logic store, input logic [9:0] a, input dataT d, input lenT len);
        ops.push_back({store, a, d, len, nextTag, store ? dataT'(0) : loadExpect(a, len)});
        nextTag = nextTag + tagT'(1);
        if (store) begin
            sbMem[a] = d[7:0];
            if (len != 2'd0) sbMem[a + 10'd1] = d[15:8];
            if (len == 2'd3) begin
                sbMem[a + 10'd2] = d[23:16];
                sbMem[a + 10'd3] = d[31:24];
            end
        end
    endtask

    task automatic driveOp(input int i);
        opValid = 1'b1;
        opStore = ops[i].store;
        opAddr = {22'b0, ops[i].addr};
        opData = ops[i].data;
        opLen = ops[i].len;
        opTag = ops[i].tag;
    endtask

    // Issues the queued operations from index start on, then checks all results in issue order.
    task automatic runQueued(input logic jitter, input int start);
        int issued;
        logic finished;
        logic accepted;
        issued = start;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (issued == ops.size() && resData.size() >= ops.size()) begin
                finished = 1'b1;
            end else begin
                if (jitter) begin
                    rdy = (randBits(2) != 32'd0);
                    memWait = (randBits(2) == 32'd0);
                end
                if (issued < ops.size() && !full) driveOp(issued);
                else opValid = 1'b0;
                accepted = opValid && rdy && !full;   // Full only moves on the rising edge.
                @(posedge clk);
                if (accepted) issued++;
            end
        end
        opValid = 1'b0;
        rdy = 1'b1;
        memWait = 1'b0;
        checkValue(dataT'(ops.size()), dataT'(resData.size()));
        for (int i = 0; i < ops.size(); i++) begin
            checkValue(dataT'(ops[i].tag), dataT'(resTag[i]));
            if (!ops[i].store) checkValue(ops[i].exp, resData[i]);
        end
        ops.delete();
        resData.delete();
        resTag.delete();
    endtask

    task automatic testWordStoreLoad();
        logic [9:0] a;
        testName = "wordStoreLoad";
        a = randAddr(2'd3);
        queueOp(1'b1, a, randBits(32), 2'd3);
        queueOp(1'b0, a, '0, 2'd3);
        runQueued(1'b0, 0);
    endtask

    task automatic testByteHalfStores();
        logic [9:0] base;
        testName = "byteHalfStores";
        base = randAddr(2'd3);
        for (int off = 0; off < 4; off++) begin
            queueOp(1'b1, base + 10'(off), randBits(32), 2'd0);
            queueOp(1'b0, base, '0, 2'd3);
        end
        for (int off = 0; off < 4; off += 2) begin
            queueOp(1'b1, base + 10'(off), randBits(32), 2'd1);
            queueOp(1'b0, base, '0, 2'd3);
        end
        for (int off = 0; off < 4; off++) queueOp(1'b0, base + 10'(off), '0, 2'd0);
        queueOp(1'b0, base, '0, 2'd1);
        queueOp(1'b0, base + 10'd2, '0, 2'd1);
        runQueued(1'b0, 0);
    endtask

    task automatic testCacheHit();
        logic [9:0] a;
        testName = "cacheHitWriteThrough";
        a = randAddr(2'd3);
        queueOp(1'b1, a, randBits(32), 2'd3);
        queueOp(1'b0, a, '0, 2'd3);
        runQueued(1'b0, 0);
        readSteps = 0;
        queueOp(1'b0, a, '0, 2'd3);
        runQueued(1'b0, 0);
        checkValue(32'd0, dataT'(readSteps));      // A hit never moves the RAM address.
        queueOp(1'b1, a + 10'd1, randBits(32), 2'd0);
        queueOp(1'b0, a, '0, 2'd3);
        runQueued(1'b0, 0);
        checkRam(a, 4);
    endtask

    task automatic testBackpressure();
        logic [9:0] a;
        testName = "bufferBackpressure";
        for (int i = 0; i < `LSB_DEPTH; i++) begin
            if (i % 2 == 0) a = randAddr(2'd3);
            queueOp(i % 2 == 0, a, randBits(32), 2'd3);
        end
        memWait = 1'b1;
        for (int i = 0; i < `LSB_DEPTH; i++) begin
            checkValue(32'd0, dataT'(full));
            driveOp(i);
            @(negedge clk);
        end
        opValid = 1'b0;
        checkValue(32'd1, dataT'(full));
        repeat (20) @(negedge clk);
        checkValue(32'd0, dataT'(resData.size()));
        memWait = 1'b0;
        runQueued(1'b0, `LSB_DEPTH);
    endtask

    task automatic testRandomTraffic();
        logic store;
        lenT  len;
        logic [9:0] a;
        testName = "randomTraffic";
        for (int i = 0; i < 24; i++) begin
            store = 1'(randBits(1));
            len = lenT'(randBits(2));
            if (len == 2'd2) len = 2'd3;
            a = randAddr(len);
            a[9:7] = 3'b000;     // 128 bytes cover the cache twice, so lines get evicted.
            queueOp(store, a, randBits(32), len);
        end
        runQueued(1'b1, 0);
        checkRam(10'd0, 1024);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        opValid = 1'b0;
        opStore = 1'b0;
        opAddr = '0;
        opData = '0;
        opLen = '0;
        opTag = '0;
        memWait = 1'b0;
        lfsr = 32'h08db357c;
        nextTag = '0;
        readSteps = 0;
        for (int i = 0; i < 1024; i++) begin
            sbMem[i[9:0]] = byteT'(i + 71 * (i >> 8));
            u_ramModel.mem[i[9:0]] = sbMem[i[9:0]];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testWordStoreLoad();
        testByteHalfStores();
        testCacheHit();
        testBackpressure();
        testRandomTraffic();
        $display("Test passed");
        $finish;
    end

endmodule

// File: testbench/ramModel.sv
`timescale 1ns/1ps

module ramModel
    import memPkg::*;
#(
    parameter int BYTES = 1024
) (
    input  logic clk,
    input  logic rdy,
    input  addrT ramAddr,
    input  logic ramWrite,
    input  byteT ramWdata,
    output byteT ramRdata
);
    localparam int AW = $clog2(BYTES);

    byteT mem [BYTES];
    logic [AW-1:0] idx;

    assign idx = ramAddr[AW-1:0];   // The upper address bits alias onto the array.

    // Read data follows the address by one cycle and holds while the core is frozen.
    always @(posedge clk) begin
        if (rdy) begin
            ramRdata <= mem[idx];
            if (ramWrite) mem[idx] <= ramWdata;
        end
    end

endmodule
